//--- Bender.yml
package:
  name: lockstep_checker

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lockstep_pkg.sv
      - verilog/accum_core.sv
      - lockstep/shadow_rst_ctrl.sv
      - lockstep/delay_line.sv
      - lockstep/output_compare.sv
      - verilog/lockstep_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_lockstep.sv

//--- common/lockstep_pkg.sv
////////////////////
// Shared types of the lockstep checker and of the accumulator core it shadows
////////////////////

`include "lockstep_settings.svh"

package lockstep_pkg;

  // Multibit enable, valid values are MUBI_ON and MUBI_OFF
  typedef logic [3:0] mubi4_t;

  ////////////////////
  // Core interface
  ////////////////////

  // Per-cycle operation presented to an accumulator core
  typedef struct packed {
    logic            op_valid;
    logic            op_clear;
    logic [`OP_W-1:0] op_data;
  } core_in_t;

  // Architectural state visible at the core outputs
  typedef struct packed {
    logic [`ACC_W-1:0] acc;
    logic [`CNT_W-1:0] op_count;
  } core_out_t;

  ////////////////////
  // Reset controller
  ////////////////////

  // HOLD keeps the shadow in reset
  // RELEASED runs the shadow with comparison still off
  typedef enum logic [1:0] {
    HOLD     = 2'd0,
    RELEASED = 2'd1,
    COMPARE  = 2'd2
  } rst_state_e;

endpackage

//--- common/lockstep_settings.svh
////////////////////
// Build-time settings for the lockstep checker, included by the package and the RTL
////////////////////

`ifndef LOCKSTEP_SETTINGS_SVH
`define LOCKSTEP_SETTINGS_SVH

// Cycles by which the shadow core lags the main core, must be 2 or more
`define LOCKSTEP_OFFSET 2

// Accumulator datapath widths
`define ACC_W 32
`define OP_W 16
`define CNT_W 8

////////////////////
// Multibit encodings
////////////////////

// Hamming distance of 4 between the two codes
`define MUBI_ON 4'h6
`define MUBI_OFF 4'h9

`endif

//--- filelist.f
+incdir+common
common/lockstep_pkg.sv
verilog/accum_core.sv
lockstep/shadow_rst_ctrl.sv
lockstep/delay_line.sv
lockstep/output_compare.sv
verilog/lockstep_top.sv
sim/tb_clk_gen.sv
sim/tb_lockstep.sv

//--- lockstep/delay_line.sv
////////////////////
// Shift register of DEPTH stages for any payload type, cleared on reset
////////////////////

`timescale 1ns/1ps

module delay_line #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 1
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  output T     data_o
);

  // Stage 0 takes the input, the last stage feeds the output
  T stage_q [DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < DEPTH; i++) begin
        stage_q[i] <= T'('0);
      end
    end else begin
      stage_q[0] <= data_i;
      for (int unsigned i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign data_o = stage_q[DEPTH-1];

  ////////////////////
  // Assertions
  ////////////////////

  // A zero-depth line would be a wire and break the lockstep alignment
  depth_valid_a : assert property (
    @(posedge clk_i) DEPTH >= 1
  ) else $error("delay_line needs DEPTH of at least 1");

endmodule

//--- lockstep/output_compare.sv
////////////////////
// Registers the shadow outputs and flags any difference from the delayed main outputs
////////////////////

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module output_compare (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_out_t shadow_i,
  input  lockstep_pkg::core_out_t main_i,
  input  lockstep_pkg::mubi4_t    cmp_en_i,
  output logic                    alert_o
);

  import lockstep_pkg::*;

  core_out_t shadow_q;
  logic      outputs_differ;

  // Extra stage that lines the shadow up with the N+1 main delay
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else begin
      shadow_q <= shadow_i;
    end
  end

  // Whole struct compare so every field counts
  assign outputs_differ = (shadow_q != main_i);

  // Any code other than MUBI_OFF enables the check so a corrupted enable still alerts
  assign alert_o = (cmp_en_i != `MUBI_OFF) && outputs_differ;

  ////////////////////
  // Assertions
  ////////////////////

  no_alert_when_off_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (cmp_en_i == `MUBI_OFF) |-> !alert_o
  ) else $error("alert raised while comparison is disabled");

endmodule

//--- lockstep/shadow_rst_ctrl.sv
////////////////////
// Holds the shadow core in reset for the lockstep offset, then enables comparison
////////////////////

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module shadow_rst_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  output logic                 shadow_rst_no,
  output lockstep_pkg::mubi4_t cmp_en_o
);

  import lockstep_pkg::*;

  localparam int unsigned Offset = `LOCKSTEP_OFFSET;
  localparam int unsigned CntW = $clog2(Offset);
  localparam logic [CntW-1:0] CntMax = CntW'(Offset - 1);

  logic [CntW-1:0] cnt_q;
  rst_state_e      state_q, state_d;
  logic            shadow_rst_n_q;
  mubi4_t          cmp_en_q;

  ////////////////////
  // Offset counter
  ////////////////////

  // Starts at reset and stops at Offset-1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cnt_q != CntMax) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      HOLD: begin
        if (cnt_q == CntMax) begin
          state_d = RELEASED;
        end
      end
      // Shadow runs for one cycle before its registered outputs are valid
      RELEASED: state_d = COMPARE;
      COMPARE:  state_d = COMPARE;
      default:  state_d = HOLD;
    endcase
  end

  // Outputs decoded from the next state, so they switch together with it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= HOLD;
      shadow_rst_n_q <= 1'b0;
      cmp_en_q       <= `MUBI_OFF;
    end else begin
      state_q        <= state_d;
      shadow_rst_n_q <= (state_d != HOLD);
      cmp_en_q       <= (state_d == COMPARE) ? `MUBI_ON : `MUBI_OFF;
    end
  end

  assign shadow_rst_no = shadow_rst_n_q;
  assign cmp_en_o      = cmp_en_q;

  ////////////////////
  // Assertions
  ////////////////////

  cnt_saturates_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntMax
  ) else $error("offset counter went past its limit");

  cmp_en_encoding_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmp_en_o inside {`MUBI_ON, `MUBI_OFF}
  ) else $error("cmp_en_o holds an invalid multibit value");

endmodule

//--- sim/tb_clk_gen.sv
////////////////////
// Testbench clock of 8 ns and an active-low reset released on a rising edge
////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned RstCycles = 2
) (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

  // Reset drops at time zero and rises on the edge after RstCycles edges
  initial begin
    rst_no = 1'b0;
    repeat (RstCycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

//--- sim/tb_lockstep.sv
////////////////////
// Directed testbench for the lockstep checker, runs a main accumulator next to the DUT
// and checks the main outputs and alert_o in every cycle
////////////////////

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module tb_lockstep;

  import lockstep_pkg::*;

  localparam int Offset     = `LOCKSTEP_OFFSET;
  localparam int AlertLag   = Offset + 1;
  // Index of the last reset cycle before release edge 0
  localparam int FirstCycle = -1;

  ////////////////////
  // Test lengths
  ////////////////////

  localparam int ResetTestCycles = 12;
  localparam int MatchedOps      = 200;
  localparam int CorruptPre      = 6;
  localparam int CorruptPost     = 6;
  localparam int DivergePre      = 4;
  localparam int DivergeRun      = 8;
  localparam int DivergeAfter    = 8;
  localparam int DrainCycles     = Offset + 2;
  localparam int TimeoutCycles   = 2 + ResetTestCycles + MatchedOps
                                 + 2 * (CorruptPre + 1 + CorruptPost)
                                 + DivergePre + DivergeRun + DivergeAfter + 2
                                 + 5 * DrainCycles + 50;

  localparam core_in_t IdleOp = '0;

  logic      clk;
  logic      rst_n;
  core_in_t  main_in;
  core_in_t  div_mask;
  core_in_t  main_core_in;
  core_out_t main_core_out;
  core_out_t corrupt_mask;
  core_out_t main_out;
  logic      alert;

  // Rule state built from main_in_i and from what the main core really receives
  core_out_t ref_model;
  core_out_t core_model;
  core_in_t  pending_ref_op;
  core_in_t  pending_core_op;
  logic      mismatch_hist[$];

  int          cyc;
  int          check_count;
  int          error_count;
  int          test_count;
  int          alert_cycles;

  ////////////////////
  // Clock, main core and DUT
  ////////////////////

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  assign main_core_in = core_in_t'(main_in ^ div_mask);
  assign main_out     = core_out_t'(main_core_out ^ corrupt_mask);

  accum_core u_main_core (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .core_i (main_core_in),
    .core_o (main_core_out)
  );

  lockstep_top dut_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .main_in_i  (main_in),
    .main_out_i (main_out),
    .alert_o    (alert)
  );

  ////////////////////
  // Reference rule and helpers
  ////////////////////

  // Clear beats a valid add
  // acc adds the unsigned operand and both fields wrap
  function automatic core_out_t apply_op(input core_out_t state, input core_in_t op);
    core_out_t next;
    next = state;
    if (op.op_clear) begin
      next = '0;
    end else if (op.op_valid) begin
      next.acc      = state.acc + op.op_data;
      next.op_count = state.op_count + 1'b1;
    end
    return next;
  endfunction

  function automatic core_in_t make_random_op(input bit allow_clear);
    core_in_t    op;
    logic [31:0] r;
    r           = $urandom;
    op.op_valid = (($urandom % 4) != 0);
    op.op_clear = allow_clear && (($urandom % 16) == 0);
    op.op_data  = r[`OP_W-1:0];
    return op;
  endfunction

  task automatic check_core_out(input string name, input core_out_t got,
                                input core_out_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED %s at cycle %0d: got %h expected %h", name, cyc, got, exp);
    end
  endtask

  task automatic check_alert(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED alert_o at cycle %0d: got %h expected %h", cyc, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR at cycle %0d: %s", cyc, what);
  endtask

  // One clock with drive on the rising edge and check on the falling edge
  task automatic run_cycle(input core_in_t op, input core_in_t div, input core_out_t mask);
    logic exp_alert;
    @(posedge clk);
    cyc++;
    // The main core first moves on edge 1 since edge 0 still sees reset
    if (cyc >= 1) begin
      ref_model  = apply_op(ref_model, pending_ref_op);
      core_model = apply_op(core_model, pending_core_op);
    end
    pending_ref_op  = op;
    pending_core_op = core_in_t'(op ^ div);
    main_in      <= op;
    div_mask     <= div;
    corrupt_mask <= mask;
    mismatch_hist.push_back(core_out_t'(core_model ^ mask) != ref_model);
    // A mismatch shows up N+1 cycles later once comparison is on
    exp_alert = 1'b0;
    if (cyc >= AlertLag) begin
      exp_alert = mismatch_hist[cyc - AlertLag - FirstCycle];
    end
    @(negedge clk);
    check_core_out("main core_o", main_core_out, core_model);
    check_alert(alert, exp_alert);
    if (alert === 1'b1) begin
      alert_cycles++;
    end
  endtask

  task automatic drain_pipeline();
    repeat (DrainCycles) begin
      run_cycle(IdleOp, IdleOp, '0);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("[%0d] %s: ok", test_count, name);
    end else begin
      $display("[%0d] %s: %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  // Corrupted value presented on the release edge where the delay lines are still in reset
  task automatic test_reset_boundary();
    int        errs;
    core_out_t mask;
    errs     = error_count;
    mask     = '0;
    mask.acc = 32'h0000_0100;
    run_cycle(IdleOp, IdleOp, mask);
    if (rst_n !== 1'b0) begin
      report_error("reset was released before the expected edge");
    end
    run_cycle(IdleOp, IdleOp, '0);
    if (rst_n !== 1'b1) begin
      report_error("reset was still asserted after the expected release edge");
    end
    repeat (ResetTestCycles - 2) begin
      run_cycle(make_random_op(1'b0), IdleOp, '0);
    end
    finish_test("corruption at reset release", errs);
  endtask

  task automatic test_matched_run();
    int errs;
    errs = error_count;
    repeat (MatchedOps) begin
      run_cycle(make_random_op(1'b1), IdleOp, '0);
    end
    drain_pipeline();
    finish_test("matched run", errs);
  endtask

  task automatic test_corrupt_field(input string name, input bit on_count);
    int          errs;
    int          alerts_before;
    core_out_t   mask;
    logic [31:0] r;
    errs          = error_count;
    alerts_before = alert_cycles;
    r             = $urandom;
    mask          = '0;
    if (on_count) begin
      mask.op_count = r[`CNT_W-1:0] | 1'b1;
    end else begin
      mask.acc = r | 32'h1;
    end
    repeat (CorruptPre) begin
      run_cycle(make_random_op(1'b0), IdleOp, '0);
    end
    run_cycle(make_random_op(1'b0), IdleOp, mask);
    repeat (CorruptPost) begin
      run_cycle(make_random_op(1'b0), IdleOp, '0);
    end
    drain_pipeline();
    if (alert_cycles - alerts_before != 1) begin
      report_error($sformatf("expected one alert cycle but saw %0d",
                             alert_cycles - alerts_before));
    end
    finish_test(name, errs);
  endtask

  // Main core gets other op_data than main_in_i for one add until a clear realigns them
  task automatic test_divergent_input();
    int          errs;
    int          alerts_before;
    core_in_t    op;
    core_in_t    div;
    logic [31:0] r;
    errs          = error_count;
    alerts_before = alert_cycles;
    repeat (DivergePre) begin
      run_cycle(make_random_op(1'b0), IdleOp, '0);
    end
    op          = make_random_op(1'b0);
    op.op_valid = 1'b1;
    r           = $urandom;
    div         = '0;
    div.op_data = r[`OP_W-1:0] | 1'b1;
    run_cycle(op, div, '0);
    repeat (DivergeRun) begin
      run_cycle(make_random_op(1'b0), IdleOp, '0);
    end
    op          = '0;
    op.op_clear = 1'b1;
    run_cycle(op, IdleOp, '0);
    repeat (DivergeAfter) begin
      run_cycle(make_random_op(1'b0), IdleOp, '0);
    end
    drain_pipeline();
    if (alert_cycles == alerts_before) begin
      report_error("divergent input never raised the alert");
    end
    finish_test("divergent input until clear", errs);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    main_in         = '0;
    div_mask        = '0;
    corrupt_mask    = '0;
    ref_model       = '0;
    core_model      = '0;
    pending_ref_op  = '0;
    pending_core_op = '0;
    cyc             = FirstCycle - 1;
    check_count     = 0;
    error_count     = 0;
    test_count      = 0;
    alert_cycles    = 0;
    void'($urandom(32'h723d));

    // Needs the cycles around the reset release and so runs first
    test_reset_boundary();
    test_matched_run();
    test_corrupt_field("acc corruption", 1'b0);
    test_corrupt_field("op_count corruption", 1'b1);
    test_divergent_input();

    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin : watchdog
    int ticks;
    ticks = 0;
    while (ticks < TimeoutCycles) begin
      @(posedge clk);
      ticks++;
    end
    $display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- verilog/accum_core.sv
////////////////////
// Small accumulator core, used as the shadow inside the checker and as the main core
////////////////////

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module accum_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  core_i,
  output lockstep_pkg::core_out_t core_o
);

  import lockstep_pkg::*;

  core_out_t state_q;
  logic [`ACC_W-1:0] operand;

  // Operand is unsigned, so zero extension
  assign operand = {{(`ACC_W - `OP_W){1'b0}}, core_i.op_data};

  ////////////////////
  // State update
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q.acc      <= '0;
      state_q.op_count <= '0;
    end else if (core_i.op_clear) begin
      // Clear has priority over a valid operation in the same cycle
      state_q.acc      <= '0;
      state_q.op_count <= '0;
    end else if (core_i.op_valid) begin
      // Both fields wrap on overflow
      state_q.acc      <= state_q.acc + operand;
      state_q.op_count <= state_q.op_count + 1'b1;
    end
  end

  // Outputs come straight from the state registers
  assign core_o = state_q;

endmodule

//--- verilog/lockstep_top.sv
////////////////////
// Lockstep checker top, runs a delayed shadow accumulator next to an external main core
// and raises alert_o when their outputs disagree
////////////////////

`timescale 1ns/1ps

`include "lockstep_settings.svh"

module lockstep_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  main_in_i,
  input  lockstep_pkg::core_out_t main_out_i,
  output logic                    alert_o
);

  import lockstep_pkg::*;

  localparam int unsigned InputDelay = `LOCKSTEP_OFFSET;
  // One more for the shadow output register
  localparam int unsigned OutputDelay = `LOCKSTEP_OFFSET + 1;

  logic      shadow_rst_n;
  mubi4_t    cmp_en;
  core_in_t  shadow_in;
  core_out_t shadow_out;
  core_out_t main_out_dly;

  ////////////////////
  // Reset sequencing
  ////////////////////

  shadow_rst_ctrl u_rst_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .shadow_rst_no (shadow_rst_n),
    .cmp_en_o      (cmp_en)
  );

  ////////////////////
  // Delay lines
  ////////////////////

  // Inputs reach the shadow N cycles after the main core
  delay_line #(
    .T     (core_in_t),
    .DEPTH (InputDelay)
  ) u_in_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_in_i),
    .data_o (shadow_in)
  );

  delay_line #(
    .T     (core_out_t),
    .DEPTH (OutputDelay)
  ) u_out_delay (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (main_out_i),
    .data_o (main_out_dly)
  );

  ////////////////////
  // Shadow core
  ////////////////////

  // Reset comes from the controller, released synchronously
  accum_core u_shadow_core (
    .clk_i  (clk_i),
    .rst_ni (shadow_rst_n),
    .core_i (shadow_in),
    .core_o (shadow_out)
  );

  ////////////////////
  // Comparison
  ////////////////////

  output_compare u_compare (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .shadow_i (shadow_out),
    .main_i   (main_out_dly),
    .cmp_en_i (cmp_en),
    .alert_o  (alert_o)
  );

endmodule
